// ==== src/fetch_pkg.sv ====
package fetch_pkg;

  // data and address width
  parameter int XLEN = 32;

  // instruction width
  parameter int ILEN = 32;

  // bus carries word addresses only
  parameter int WADR_W = XLEN - 2;

  // cache line fill machine
  typedef enum logic [1:0] {
    fetch_idle,
    fetch_arb,
    fetch_read,
    fetch_done
  } fetch_state_t;

  // vector table fetch machine
  typedef enum logic [1:0] {
    vec_idle,
    vec_arb,
    vec_read,
    vec_done
  } vec_state_t;

  // load/store port
  typedef enum logic [1:0] {
    port_idle,
    port_arb,
    port_wait
  } port_state_t;

endpackage

// ==== src/inst_cache.sv ====
`timescale 1ns/10ps

module inst_cache #(
  parameter int CACHE_LEN = 6,
  parameter int LINE_LEN = 3,
  parameter logic [fetch_pkg::XLEN-1:0] VTABLE_ADDRESS = 32'h100
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         advance_i,
  input  logic                         interrupt_i,
  input  logic [fetch_pkg::XLEN-1:0]   addr_i,
  input  logic [fetch_pkg::XLEN-1:0]   vtable_offset_i,
  output logic                         busy_o,
  output logic                         vtable_pc_valid_o,
  output logic [fetch_pkg::ILEN-1:0]   instruction_o,
  output logic [fetch_pkg::XLEN-1:0]   vtable_pc_o,
  output logic                         bus_req_o,
  input  logic                         bus_grant_i,
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output logic [fetch_pkg::WADR_W-1:0] wb_adr_o,
  input  logic [fetch_pkg::XLEN-1:0]   wb_dat_i,
  input  logic                         wb_ack_i
);

  import fetch_pkg::*;

  localparam int LINE_W = CACHE_LEN - LINE_LEN;
  localparam int LINES = 2 ** LINE_W;
  localparam int TAG_W = WADR_W - LINE_LEN;

  // tags, valid bits and the word storage
  logic [TAG_W-1:0]  tag_q [LINES];
  logic [LINES-1:0]  valid_q;
  logic [ILEN-1:0]   data_mem [2**CACHE_LEN];
  logic [LINE_W-1:0] victim_q;

  logic [TAG_W-1:0]  lookup_tag;
  logic              hit;
  logic [LINE_W-1:0] hit_line;

  fetch_state_t        fill_state_q;
  logic [TAG_W-1:0]    fill_tag_q;
  logic [LINE_LEN-1:0] word_idx_q;
  logic                fill_active;

  vec_state_t        vec_state_q;
  logic [WADR_W-1:0] vec_adr_q;
  logic              vec_active;
  logic              vec_seen_q;
  logic              irq_pend_q;

  logic accept;
  logic vec_start;
  logic miss_start;
  logic fill_beat;
  logic vec_beat;

  assign lookup_tag = addr_i[XLEN-1:LINE_LEN+2];

  // fully associative match over all lines
  always_comb begin
    hit = 1'b0;
    hit_line = '0;
    for (int i = 0; i < LINES; i++) begin
      if (valid_q[i] && (tag_q[i] == lookup_tag)) begin
        hit = 1'b1;
        hit_line = LINE_W'(i);
      end
    end
  end

  assign busy_o = (fill_state_q != fetch_idle) || (vec_state_q != vec_idle);
  assign accept = advance_i && !busy_o;
  // first advance after reset or after an interrupt goes to the vector table
  assign vec_start = accept && (!vec_seen_q || irq_pend_q);
  assign miss_start = accept && !vec_start && !hit;

  assign fill_active = (fill_state_q == fetch_arb) || (fill_state_q == fetch_read);
  assign vec_active = (vec_state_q == vec_arb) || (vec_state_q == vec_read);
  assign fill_beat = (fill_state_q == fetch_read) && wb_ack_i;
  assign vec_beat = (vec_state_q == vec_read) && wb_ack_i;

  // only one machine runs at a time, so the bus outputs are a plain mux
  assign bus_req_o = fill_active || vec_active;
  assign wb_cyc_o = (fill_state_q == fetch_read) || (vec_state_q == vec_read);
  assign wb_stb_o = wb_cyc_o;
  assign wb_adr_o = fill_active ? {fill_tag_q, word_idx_q} : vec_adr_q;

  // registered read port
  always_ff @(posedge clk_i) begin
    if (accept) begin
      instruction_o <= data_mem[{hit_line, addr_i[LINE_LEN+1:2]}];
    end
  end

  // line data and tag written during the fill
  always_ff @(posedge clk_i) begin
    if (miss_start) begin
      fill_tag_q <= lookup_tag;
    end
    if (fill_beat) begin
      data_mem[{victim_q, word_idx_q}] <= wb_dat_i;
    end
    if (fill_state_q == fetch_done) begin
      tag_q[victim_q] <= fill_tag_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fill_state_q <= fetch_idle;
      word_idx_q <= '0;
      victim_q <= '0;
      valid_q <= '0;
    end else begin
      case (fill_state_q)
        fetch_idle: begin
          if (miss_start) begin
            word_idx_q <= '0;
            fill_state_q <= fetch_arb;
          end
        end
        fetch_arb: begin
          if (bus_grant_i) begin
            fill_state_q <= fetch_read;
          end
        end
        fetch_read: begin
          // words arrive in order, last one ends the burst
          if (wb_ack_i) begin
            word_idx_q <= word_idx_q + 1'b1;
            if (&word_idx_q) begin
              fill_state_q <= fetch_done;
            end
          end
        end
        fetch_done: begin
          valid_q[victim_q] <= 1'b1;
          victim_q <= victim_q + 1'b1;
          fill_state_q <= fetch_idle;
        end
        default: fill_state_q <= fetch_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (vec_start) begin
      vec_adr_q <= VTABLE_ADDRESS[XLEN-1:2] + vtable_offset_i[XLEN-1:2];
    end
    if (vec_beat) begin
      vtable_pc_o <= wb_dat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vec_state_q <= vec_idle;
      vec_seen_q <= 1'b0;
      irq_pend_q <= 1'b0;
      vtable_pc_valid_o <= 1'b0;
    end else begin
      vtable_pc_valid_o <= 1'b0;
      // sticky until the next vector fetch starts
      if (interrupt_i) begin
        irq_pend_q <= 1'b1;
      end else if (vec_start) begin
        irq_pend_q <= 1'b0;
      end
      case (vec_state_q)
        vec_idle: begin
          if (vec_start) begin
            vec_seen_q <= 1'b1;
            vec_state_q <= vec_arb;
          end
        end
        vec_arb: begin
          if (bus_grant_i) begin
            vec_state_q <= vec_read;
          end
        end
        vec_read: begin
          if (wb_ack_i) begin
            vtable_pc_valid_o <= 1'b1;
            vec_state_q <= vec_done;
          end
        end
        default: vec_state_q <= vec_idle;
      endcase
    end
  end

endmodule

// ==== src/data_port.sv ====
`timescale 1ns/10ps

module data_port (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         req_valid_i,
  input  logic                         req_we_i,
  input  logic [fetch_pkg::XLEN-1:0]   req_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]   req_wdata_i,
  output logic                         req_ready_o,
  output logic                         resp_valid_o,
  output logic [fetch_pkg::XLEN-1:0]   resp_rdata_o,
  output logic                         bus_req_o,
  input  logic                         bus_grant_i,
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output logic                         wb_we_o,
  output logic [fetch_pkg::WADR_W-1:0] wb_adr_o,
  output logic [fetch_pkg::XLEN-1:0]   wb_dat_o,
  input  logic [fetch_pkg::XLEN-1:0]   wb_dat_i,
  input  logic                         wb_ack_i
);

  import fetch_pkg::*;

  port_state_t state_q;
  logic        we_q;

  assign req_ready_o = (state_q == port_idle);
  assign bus_req_o = (state_q != port_idle);
  // single beat, cycle and strobe together
  assign wb_cyc_o = (state_q == port_wait);
  assign wb_stb_o = wb_cyc_o;
  assign wb_we_o = we_q;

  // request payload, held until the response
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      we_q <= req_we_i;
      wb_adr_o <= req_addr_i[XLEN-1:2];
      wb_dat_o <= req_wdata_i;
    end
    if (wb_cyc_o && wb_ack_i && !we_q) begin
      resp_rdata_o <= wb_dat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= port_idle;
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= 1'b0;
      case (state_q)
        port_idle: if (req_valid_i) state_q <= port_arb;
        port_arb:  if (bus_grant_i) state_q <= port_wait;
        port_wait: begin
          if (wb_ack_i) begin
            resp_valid_o <= 1'b1;
            state_q <= port_idle;
          end
        end
        default: state_q <= port_idle;
      endcase
    end
  end

endmodule

// ==== src/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         m0_req_i,
  input  logic                         m0_cyc_i,
  input  logic                         m0_stb_i,
  input  logic                         m0_we_i,
  input  logic [fetch_pkg::WADR_W-1:0] m0_adr_i,
  input  logic [fetch_pkg::XLEN-1:0]   m0_dat_i,
  output logic                         m0_grant_o,
  output logic                         m0_ack_o,
  output logic [fetch_pkg::XLEN-1:0]   m0_dat_o,
  input  logic                         m1_req_i,
  input  logic                         m1_cyc_i,
  input  logic                         m1_stb_i,
  input  logic                         m1_we_i,
  input  logic [fetch_pkg::WADR_W-1:0] m1_adr_i,
  input  logic [fetch_pkg::XLEN-1:0]   m1_dat_i,
  output logic                         m1_grant_o,
  output logic                         m1_ack_o,
  output logic [fetch_pkg::XLEN-1:0]   m1_dat_o,
  output logic                         s_cyc_o,
  output logic                         s_stb_o,
  output logic                         s_we_o,
  output logic [fetch_pkg::WADR_W-1:0] s_adr_o,
  output logic [fetch_pkg::XLEN-1:0]   s_dat_o,
  input  logic                         s_ack_i,
  input  logic [fetch_pkg::XLEN-1:0]   s_dat_i
);

  // one-hot owner, zero while the bus is free
  logic [1:0] owner_q;
  // set when m1 won the last grant
  logic       last_q;
  logic       pick_m1;

  assign pick_m1 = m1_req_i && (!m0_req_i || !last_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner_q <= 2'b00;
      last_q <= 1'b1;
    end else if (owner_q == 2'b00) begin
      if (m0_req_i || m1_req_i) begin
        owner_q <= pick_m1 ? 2'b10 : 2'b01;
        last_q <= pick_m1;
      end
    end else if ((owner_q[0] && !m0_req_i) || (owner_q[1] && !m1_req_i)) begin
      owner_q <= 2'b00;
    end
  end

  assign m0_grant_o = owner_q[0];
  assign m1_grant_o = owner_q[1];
  assign m0_ack_o = owner_q[0] && s_ack_i;
  assign m1_ack_o = owner_q[1] && s_ack_i;
  assign m0_dat_o = owner_q[0] ? s_dat_i : '0;
  assign m1_dat_o = owner_q[1] ? s_dat_i : '0;

  assign s_cyc_o = owner_q[1] ? m1_cyc_i : (owner_q[0] && m0_cyc_i);
  assign s_stb_o = owner_q[1] ? m1_stb_i : (owner_q[0] && m0_stb_i);
  assign s_we_o = owner_q[1] ? m1_we_i : (owner_q[0] && m0_we_i);
  assign s_adr_o = owner_q[1] ? m1_adr_i : m0_adr_i;
  assign s_dat_o = owner_q[1] ? m1_dat_i : m0_dat_i;

endmodule

// ==== src/main_memory.sv ====
`timescale 1ns/10ps

module main_memory #(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [fetch_pkg::WADR_W-1:0] wb_adr_i,
  input  logic [fetch_pkg::XLEN-1:0]   wb_dat_i,
  output logic                         wb_ack_o,
  output logic [fetch_pkg::XLEN-1:0]   wb_dat_o
);

  import fetch_pkg::*;

  logic [XLEN-1:0]          mem [2**MEM_ADDR_BITS];
  logic [MEM_ADDR_BITS-1:0] index;
  logic                     beat_req;

  // upper address bits wrap onto the array
  assign index = wb_adr_i[MEM_ADDR_BITS-1:0];
  assign beat_req = wb_cyc_i && wb_stb_i;

  // ack one cycle after a strobe that is not yet acknowledged
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= beat_req && !wb_ack_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_req && !wb_ack_o) begin
      wb_dat_o <= mem[index];
    end
    // write lands on the acknowledged beat
    if (beat_req && wb_we_i && wb_ack_o) begin
      mem[index] <= wb_dat_i;
    end
  end

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top #(
  parameter int CACHE_LEN = 6,
  parameter int LINE_LEN = 3,
  parameter int MEM_ADDR_BITS = 10,
  parameter logic [fetch_pkg::XLEN-1:0] VTABLE_ADDRESS = 32'h100
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       advance_i,
  input  logic                       interrupt_i,
  input  logic [fetch_pkg::XLEN-1:0] addr_i,
  input  logic [fetch_pkg::XLEN-1:0] vtable_offset_i,
  output logic                       busy_o,
  output logic                       vtable_pc_valid_o,
  output logic [fetch_pkg::ILEN-1:0] instruction_o,
  output logic [fetch_pkg::XLEN-1:0] vtable_pc_o,
  input  logic                       req_valid_i,
  input  logic                       req_we_i,
  input  logic [fetch_pkg::XLEN-1:0] req_addr_i,
  input  logic [fetch_pkg::XLEN-1:0] req_wdata_i,
  output logic                       req_ready_o,
  output logic                       resp_valid_o,
  output logic [fetch_pkg::XLEN-1:0] resp_rdata_o
);

  import fetch_pkg::*;

  // cache side of the arbiter
  logic              c_req, c_grant, c_cyc, c_stb, c_ack;
  logic [WADR_W-1:0] c_adr;
  logic [XLEN-1:0]   c_rdat;

  // data port side
  logic              d_req, d_grant, d_cyc, d_stb, d_we, d_ack;
  logic [WADR_W-1:0] d_adr;
  logic [XLEN-1:0]   d_wdat, d_rdat;

  // slave side
  logic              s_cyc, s_stb, s_we, s_ack;
  logic [WADR_W-1:0] s_adr;
  logic [XLEN-1:0]   s_wdat, s_rdat;

  inst_cache #(
    .CACHE_LEN      (CACHE_LEN),
    .LINE_LEN       (LINE_LEN),
    .VTABLE_ADDRESS (VTABLE_ADDRESS)
  ) inst_cache_inst (
    .clk_i, .reset_i, .advance_i, .interrupt_i, .addr_i, .vtable_offset_i,
    .busy_o, .vtable_pc_valid_o, .instruction_o, .vtable_pc_o,
    .bus_req_o (c_req), .bus_grant_i (c_grant), .wb_cyc_o (c_cyc), .wb_stb_o (c_stb),
    .wb_adr_o (c_adr), .wb_dat_i (c_rdat), .wb_ack_i (c_ack)
  );

  data_port data_port_inst (
    .clk_i, .reset_i, .req_valid_i, .req_we_i, .req_addr_i, .req_wdata_i,
    .req_ready_o, .resp_valid_o, .resp_rdata_o,
    .bus_req_o (d_req), .bus_grant_i (d_grant), .wb_cyc_o (d_cyc), .wb_stb_o (d_stb),
    .wb_we_o (d_we), .wb_adr_o (d_adr), .wb_dat_o (d_wdat), .wb_dat_i (d_rdat),
    .wb_ack_i (d_ack)
  );

  // the cache only reads
  bus_arbiter bus_arbiter_inst (
    .clk_i, .reset_i,
    .m0_req_i (c_req), .m0_cyc_i (c_cyc), .m0_stb_i (c_stb), .m0_we_i (1'b0),
    .m0_adr_i (c_adr), .m0_dat_i ('0), .m0_grant_o (c_grant), .m0_ack_o (c_ack),
    .m0_dat_o (c_rdat),
    .m1_req_i (d_req), .m1_cyc_i (d_cyc), .m1_stb_i (d_stb), .m1_we_i (d_we),
    .m1_adr_i (d_adr), .m1_dat_i (d_wdat), .m1_grant_o (d_grant), .m1_ack_o (d_ack),
    .m1_dat_o (d_rdat),
    .s_cyc_o (s_cyc), .s_stb_o (s_stb), .s_we_o (s_we), .s_adr_o (s_adr),
    .s_dat_o (s_wdat), .s_ack_i (s_ack), .s_dat_i (s_rdat)
  );

  main_memory #(
    .MEM_ADDR_BITS (MEM_ADDR_BITS)
  ) main_memory_inst (
    .clk_i, .reset_i,
    .wb_cyc_i (s_cyc), .wb_stb_i (s_stb), .wb_we_i (s_we), .wb_adr_i (s_adr),
    .wb_dat_i (s_wdat), .wb_ack_o (s_ack), .wb_dat_o (s_rdat)
  );

endmodule

// ==== test/tb_fetch_top.sv ====
`timescale 1ns/10ps

module tb_fetch_top;

  import fetch_pkg::*;

  localparam int CACHE_LEN = 6;
  localparam int LINE_LEN = 3;
  localparam int MEM_ADDR_BITS = 10;
  localparam logic [XLEN-1:0] VTABLE_ADDRESS = 32'h100;
  localparam int MEM_WORDS = 2 ** MEM_ADDR_BITS;
  localparam int LINES = 2 ** (CACHE_LEN - LINE_LEN);
  localparam int NUM_TESTS = 6;
  localparam int WORDS_PER_TEST = MEM_WORDS;
  localparam int WAIT_LIMIT = 200;

  logic            clk_i, reset_i, advance_i, interrupt_i;
  logic [XLEN-1:0] addr_i, vtable_offset_i;
  logic            busy_o, vtable_pc_valid_o;
  logic [ILEN-1:0] instruction_o;
  logic [XLEN-1:0] vtable_pc_o;
  logic            req_valid_i, req_we_i, req_ready_o, resp_valid_o;
  logic [XLEN-1:0] req_addr_i, req_wdata_i, resp_rdata_o;

  // memory contents and the expected tag array of the cache
  logic [XLEN-1:0]  mem_model [MEM_WORDS];
  logic [XLEN-1:0]  tag_model [LINES];
  logic [LINES-1:0] valid_model;
  int               victim_model;

  logic [31:0] seed = 32'h90fa;
  int error_count = 0;
  int test_errors = 0;
  int test_num = 0;
  int pass_count = 0;
  int fail_count = 0;
  int resp_count = 0;
  int accept_count = 0;

  fetch_top #(
    .CACHE_LEN      (CACHE_LEN),
    .LINE_LEN       (LINE_LEN),
    .MEM_ADDR_BITS  (MEM_ADDR_BITS),
    .VTABLE_ADDRESS (VTABLE_ADDRESS)
  ) fetch_top_inst (.*);

  always #5 clk_i = ~clk_i;

  // every response pulse, whoever is waiting for it
  always @(negedge clk_i) begin
    if (resp_valid_o === 1'b1) resp_count++;
  end

  initial begin
    repeat (NUM_TESTS * WORDS_PER_TEST * 40) @(posedge clk_i);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int random_index();
    return int'((next_random() >> 16) % MEM_WORDS);
  endfunction

  function automatic logic [XLEN-1:0] line_tag(input logic [XLEN-1:0] addr);
    return addr >> (LINE_LEN + 2);
  endfunction

  function automatic bit resident(input logic [XLEN-1:0] addr);
    bit found;
    found = 1'b0;
    for (int i = 0; i < LINES; i++) begin
      if (valid_model[i] && tag_model[i] == line_tag(addr)) found = 1'b1;
    end
    return found;
  endfunction

  task automatic check(input string name, input logic [XLEN-1:0] got,
                       input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy_o && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (busy_o) begin
      $display("busy_o stayed high for %0d cycles", WAIT_LIMIT);
      error_count++;
    end
  endtask

  // one load or store through the data port, returns the read data
  task automatic access(input logic we, input logic [XLEN-1:0] addr,
                        input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata);
    int cycles;
    cycles = 0;
    if (!req_ready_o) begin
      $display("data port not ready for a new request");
      error_count++;
    end
    req_valid_i = 1'b1;
    req_we_i = we;
    req_addr_i = addr;
    req_wdata_i = wdata;
    @(posedge clk_i);
    #1;
    accept_count++;
    req_valid_i = 1'b0;
    while (!resp_valid_o && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!resp_valid_o) begin
      $display("no data port response for address %h", addr);
      error_count++;
    end
    rdata = resp_rdata_o;
  endtask

  // fetch one word, refilling on a miss, and keep the tag model in step
  task automatic fetch(input logic [XLEN-1:0] addr, output bit missed);
    bit expect_miss;
    bit done;
    int tries;
    expect_miss = !resident(addr);
    missed = 1'b0;
    done = 1'b0;
    tries = 0;
    while (!done && tries < 3) begin
      advance_i = 1'b1;
      addr_i = addr;
      @(posedge clk_i);
      #1;
      advance_i = 1'b0;
      if (busy_o) begin
        if (tries == 0) missed = 1'b1;
        wait_idle();
      end else begin
        check("instruction_o", instruction_o, mem_model[(addr >> 2) % MEM_WORDS]);
        done = 1'b1;
      end
      tries++;
    end
    if (!done) begin
      $display("fetch of %h still missed after the line fill", addr);
      error_count++;
    end
    check("busy_o", 32'(missed), 32'(expect_miss));
    if (missed) begin
      tag_model[victim_model] = line_tag(addr);
      valid_model[victim_model] = 1'b1;
      victim_model = (victim_model + 1) % LINES;
    end
  endtask

  // advance that starts a vector fetch, expects exactly one pc pulse
  task automatic fetch_vector(input logic [XLEN-1:0] offset);
    int pulses;
    int cycles;
    pulses = 0;
    cycles = 0;
    vtable_offset_i = offset;
    advance_i = 1'b1;
    addr_i = '0;
    @(posedge clk_i);
    #1;
    advance_i = 1'b0;
    while (busy_o && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      #1;
      cycles++;
      if (vtable_pc_valid_o) begin
        pulses++;
        check("vtable_pc_o", vtable_pc_o, mem_model[((VTABLE_ADDRESS + offset) >> 2) % MEM_WORDS]);
      end
    end
    if (busy_o) begin
      $display("vector fetch did not finish");
      error_count++;
    end
    check("vtable_pc_valid_o pulses", 32'(pulses), 32'd1);
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (error_count == test_errors) pass_count++;
    else fail_count++;
    $display("test %0d %s: %s", test_num, name,
             (error_count == test_errors) ? "passed" : "failed");
    test_errors = error_count;
  endtask

  initial begin
    logic [XLEN-1:0] data;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] first_addr;
    bit              missed;
    int              idx;
    int              idx2;
    clk_i = 1'b0;
    reset_i = 1'b1;
    advance_i = 1'b0;
    interrupt_i = 1'b0;
    addr_i = '0;
    vtable_offset_i = '0;
    req_valid_i = 1'b0;
    req_we_i = 1'b0;
    req_addr_i = '0;
    req_wdata_i = '0;
    valid_model = '0;
    victim_model = 0;
    repeat (10) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    check("busy_o", 32'(busy_o), 32'd0);
    check("req_ready_o", 32'(req_ready_o), 32'd1);
    for (int i = 0; i < MEM_WORDS; i++) begin
      data = next_random();
      mem_model[i] = data;
      access(1'b1, i * 4, data, rdata);
    end
    for (int i = 0; i < 64; i++) begin
      idx = random_index();
      access(1'b0, idx * 4, '0, rdata);
      check("resp_rdata_o", rdata, mem_model[idx]);
    end
    end_test("preload and readback");

    fetch_vector((next_random() >> 20) % 64 * 4);
    end_test("first advance vector fetch");

    for (int i = 0; i < 64; i++) begin
      fetch(random_index() * 4, missed);
    end
    end_test("fetch correctness");

    // nine distinct lines through an eight line cache evict the first one
    do first_addr = random_index() * 4; while (resident(first_addr));
    fetch(first_addr, missed);
    fetch({first_addr[XLEN-1:5], 5'h14}, missed);
    check("busy_o", 32'(missed), 32'd0);
    for (int i = 0; i < LINES; i++) begin
      do addr = random_index() * 4; while (resident(addr));
      fetch(addr, missed);
    end
    fetch(first_addr, missed);
    check("busy_o", 32'(missed), 32'd1);
    end_test("hit timing and replacement");

    for (int i = 0; i < 4; i++) begin
      interrupt_i = 1'b1;
      @(posedge clk_i);
      #1;
      interrupt_i = 1'b0;
      fetch_vector((next_random() >> 20) % 64 * 4);
    end
    end_test("interrupt vector");

    for (int r = 0; r < 4; r++) begin
      do addr = random_index() * 4; while (resident(addr));
      fork
        fetch(addr, missed);
        for (int k = 0; k < 4; k++) begin
          idx2 = random_index();
          access(1'b0, idx2 * 4, '0, rdata2);
          check("resp_rdata_o", rdata2, mem_model[idx2]);
        end
      join
    end
    repeat (4) @(posedge clk_i);
    #1;
    check("resp_valid_o count", 32'(resp_count), 32'(accept_count));
    end_test("contention");

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
src/fetch_pkg.sv
src/inst_cache.sv
src/data_port.sv
src/bus_arbiter.sv
src/main_memory.sv
src/fetch_top.sv
test/tb_fetch_top.sv

// ==== Makefile ====
# Verilator flow for the fetch subsystem

OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall --top-module fetch_top -f project.f

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_fetch_top \
		-f project.f -Mdir $(OBJ_DIR) -o sim_fetch
	./$(OBJ_DIR)/sim_fetch | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
